//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

  // instruction word and its fields.
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [1:0]  op_group_t;

  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;

  // opcode groups, top two opcode bits.
  localparam op_group_t GRP_REG_ALU = 2'b00;
  localparam op_group_t GRP_IMM_ALU = 2'b01;
  localparam op_group_t GRP_MEMORY  = 2'b10;
  localparam op_group_t GRP_BRANCH  = 2'b11;

  localparam opcode_t OP_NOP   = 6'b000000;
  localparam opcode_t OP_CMP   = 6'b001000;
  localparam opcode_t OP_TEST  = 6'b001001;
  localparam opcode_t OP_CMPI  = 6'b011000;
  localparam opcode_t OP_TESTI = 6'b011001;
  localparam opcode_t OP_LW    = 6'b100000;
  localparam opcode_t OP_SW    = 6'b100001;
  localparam opcode_t OP_JMP   = 6'b110000; // unconditional.

  // which register fields an instruction really uses.
  typedef logic [2:0] reg_mask_t;

  localparam reg_mask_t REG_MASK_RS0 = 3'b001;
  localparam reg_mask_t REG_MASK_RS1 = 3'b010;
  localparam reg_mask_t REG_MASK_RD  = 3'b100;

  typedef logic [1:0] pipe_t;

  localparam pipe_t PIPE_ANY    = 2'd0;
  localparam pipe_t PIPE_BRANCH = 2'd1; // lane 0.
  localparam pipe_t PIPE_MEMORY = 2'd2; // lane 1.

endpackage

`default_nettype wire

//--- issue_pkg.sv
`default_nettype none

package issue_pkg;

  import isa_pkg::*;

  localparam int IQ_DEPTH = 8;

  typedef logic [2:0]  iq_idx_t;
  typedef logic [3:0]  iq_cnt_t; // 0 to 8.
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  inst_id_t;

  // one window slot.
  typedef struct packed {
    inst_t    instruction;
    addr_t    pc;
    inst_id_t id;
  } iq_entry_t;

  // decoded view of one slot, used by the hazard check and steering.
  typedef struct packed {
    reg_idx_t  src0;
    reg_idx_t  src1;
    reg_idx_t  dest;
    reg_mask_t use_mask;
    logic      is_branch; // conditional branch only.
    logic      is_cmp;
    logic      is_mem;
    pipe_t     pipe;
  } operands_t;

  typedef struct packed {
    logic      valid;
    iq_entry_t entry;
  } issue_lane_t;

endpackage

`default_nettype wire

//--- issue_route.sv
`timescale 1ns/1ps
`default_nettype none

module issue_route
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      flush,
  input  logic                      pop0,
  input  logic                      pop1,
  input  iq_idx_t                   pop_key0,
  input  iq_idx_t                   pop_key1,
  input  iq_entry_t [IQ_DEPTH-1:0]  entries,
  input  operands_t [IQ_DEPTH-1:0]  ops,
  output issue_lane_t               lane0,
  output issue_lane_t               lane1
);

  issue_lane_t older;
  issue_lane_t younger;
  issue_lane_t lane0_nxt;
  issue_lane_t lane1_nxt;
  logic        swap;

  assign older   = '{valid: pop0, entry: entries[pop_key0]};
  assign younger = '{valid: pop1, entry: entries[pop_key1]};

  // older moves to the memory lane if it needs it or the branch lane is wanted.
  assign swap = (ops[pop_key0].pipe == PIPE_MEMORY) ||
                (pop1 && (ops[pop_key1].pipe == PIPE_BRANCH));

  always_comb begin
    if (swap) begin
      lane0_nxt = younger;
      lane1_nxt = older;
    end else begin
      lane0_nxt = older;
      lane1_nxt = younger;
    end
  end

  always_ff @(posedge clk) begin
    lane0.entry <= lane0_nxt.entry;
    lane1.entry <= lane1_nxt.entry;
    if (rst || flush) begin
      lane0.valid <= 1'b0;
      lane1.valid <= 1'b0;
    end else begin
      lane0.valid <= lane0_nxt.valid;
      lane1.valid <= lane1_nxt.valid;
    end
  end

endmodule

`default_nettype wire

//--- issue_select.sv
`timescale 1ns/1ps
`default_nettype none

module issue_select
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  logic      [IQ_DEPTH-1:0]  valid,
  input  operands_t [IQ_DEPTH-1:0]  ops,
  output logic                      pop0,
  output logic                      pop1,
  output iq_idx_t                   pop_key0,
  output iq_idx_t                   pop_key1
);

  logic [IQ_DEPTH-1:0][IQ_DEPTH-1:0] conflict; // [younger][older].
  logic [IQ_DEPTH-1:0]               pick0_hot;
  logic [IQ_DEPTH-1:0]               cand;

  ////////////////////////////////////////
  // pair checks
  ////////////////////////////////////////

  function automatic logic has_reg(operands_t op, reg_mask_t bit_sel);
    return (op.use_mask & bit_sel) != '0;
  endfunction

  // rd_op reads a register that wr_op writes.
  function automatic logic reads_dest(operands_t rd_op, operands_t wr_op);
    logic hit0;
    logic hit1;
    hit0 = has_reg(rd_op, REG_MASK_RS0) && (rd_op.src0 == wr_op.dest);
    hit1 = has_reg(rd_op, REG_MASK_RS1) && (rd_op.src1 == wr_op.dest);
    return has_reg(wr_op, REG_MASK_RD) && (hit0 || hit1);
  endfunction

  function automatic logic pair_conflict(operands_t young, operands_t old, logic waive);
    logic raw;
    logic war;
    logic waw;
    logic cmp_br;
    raw    = reads_dest(young, old);
    war    = reads_dest(old, young);
    waw    = has_reg(young, REG_MASK_RD) && has_reg(old, REG_MASK_RD) &&
             (young.dest == old.dest);
    cmp_br = (young.is_cmp && old.is_branch) || (young.is_branch && old.is_cmp);
    // old leaves this same cycle when it is pick 0.
    return raw || cmp_br || (young.is_mem && old.is_mem) ||
           (!waive && (war || waw || old.is_branch));
  endfunction

  // two of the same dedicated pipe cannot go out together.
  function automatic logic steer_block(pipe_t first, pipe_t second);
    return ((first == PIPE_BRANCH) && (second == PIPE_BRANCH)) ||
           ((first == PIPE_MEMORY) && (second == PIPE_MEMORY));
  endfunction

  ////////////////////////////////////////
  // picks
  ////////////////////////////////////////

  // oldest always goes first.
  assign pop0     = valid[0];
  assign pop_key0 = '0;

  always_comb begin
    pick0_hot           = '0;
    pick0_hot[pop_key0] = pop0;
  end

  always_comb begin
    conflict = '0;
    for (int i = 1; i < IQ_DEPTH; i++) begin
      for (int j = 0; j < i; j++) begin
        conflict[i][j] = valid[j] && pair_conflict(ops[i], ops[j], pick0_hot[j]);
      end
    end
  end

  always_comb begin
    cand = '0;
    for (int i = 1; i < IQ_DEPTH; i++) begin
      cand[i] = valid[i] && !(|conflict[i]) &&
                !steer_block(ops[pop_key0].pipe, ops[i].pipe);
    end
  end

  // lowest free candidate wins.
  always_comb begin
    pop1     = 1'b0;
    pop_key1 = '0;
    for (int i = IQ_DEPTH - 1; i > 0; i--) begin
      if (cand[i]) begin
        pop1     = 1'b1;
        pop_key1 = iq_idx_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

//--- issue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_top
  import issue_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        flush,
  input  logic        push0,
  input  logic        push1,
  input  iq_entry_t   push_data0,
  input  iq_entry_t   push_data1,
  output logic        stall,
  output issue_lane_t lane0,
  output issue_lane_t lane1
);

  iq_entry_t [IQ_DEPTH-1:0] entries;
  operands_t [IQ_DEPTH-1:0] ops;
  logic      [IQ_DEPTH-1:0] valid;
  logic                     pop0;
  logic                     pop1;
  iq_idx_t                  pop_key0;
  iq_idx_t                  pop_key1;

  issue_window u_window (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .push0      (push0),
    .push1      (push1),
    .push_data0 (push_data0),
    .push_data1 (push_data1),
    .pop0       (pop0),
    .pop1       (pop1),
    .pop_key0   (pop_key0),
    .pop_key1   (pop_key1),
    .entries    (entries),
    .valid      (valid),
    .stall      (stall)
  );

  // one decoder per slot.
  for (genvar i = 0; i < IQ_DEPTH; i++) begin : g_decode
    reg_decode u_decode (
      .instruction (entries[i].instruction),
      .ops         (ops[i])
    );
  end

  issue_select u_select (
    .valid    (valid),
    .ops      (ops),
    .pop0     (pop0),
    .pop1     (pop1),
    .pop_key0 (pop_key0),
    .pop_key1 (pop_key1)
  );

  issue_route u_route (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .pop0     (pop0),
    .pop1     (pop1),
    .pop_key0 (pop_key0),
    .pop_key1 (pop_key1),
    .entries  (entries),
    .ops      (ops),
    .lane0    (lane0),
    .lane1    (lane1)
  );

endmodule

`default_nettype wire

//--- issue_window.sv
`timescale 1ns/1ps
`default_nettype none

module issue_window
  import issue_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush,
  input  logic                       push0,
  input  logic                       push1,
  input  iq_entry_t                  push_data0,
  input  iq_entry_t                  push_data1,
  input  logic                       pop0,
  input  logic                       pop1,
  input  iq_idx_t                    pop_key0,
  input  iq_idx_t                    pop_key1,
  output iq_entry_t [IQ_DEPTH-1:0]   entries,
  output logic      [IQ_DEPTH-1:0]   valid,
  output logic                       stall
);

  iq_cnt_t                   count;
  iq_cnt_t                   count_nxt;
  iq_entry_t [IQ_DEPTH-1:0]  entries_nxt;
  logic      [IQ_DEPTH-1:0]  kill;
  logic      [IQ_DEPTH-1:0]  keep;

  ////////////////////////////////////////
  // occupancy
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      valid[i] = (iq_cnt_t'(i) < count); // always packed at the bottom.
    end
  end

  // fewer than two slots free, same-cycle pops not counted.
  assign stall = (count > iq_cnt_t'(IQ_DEPTH - 2));

  ////////////////////////////////////////
  // pop, compact, append
  ////////////////////////////////////////

  always_comb begin
    kill           = '0;
    kill[pop_key0] = pop0;
    if (pop1) begin
      kill[pop_key1] = 1'b1;
    end
  end

  assign keep = valid & ~kill;

  always_comb begin
    count_nxt   = '0;
    entries_nxt = entries;

    // survivors slide down in age order.
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (keep[i]) begin
        entries_nxt[iq_idx_t'(count_nxt)] = entries[i];
        count_nxt                         = count_nxt + 1'b1;
      end
    end

    // new ones behind them, push0 first.
    if (push0 && !stall) begin
      entries_nxt[iq_idx_t'(count_nxt)] = push_data0;
      count_nxt                         = count_nxt + 1'b1;
    end
    if (push1 && !stall) begin
      entries_nxt[iq_idx_t'(count_nxt)] = push_data1;
      count_nxt                         = count_nxt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    entries <= entries_nxt;
    if (rst || flush) begin
      count <= '0;
    end else begin
      count <= count_nxt;
    end
  end

endmodule

`default_nettype wire

//--- reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module reg_decode
  import isa_pkg::*;
  import issue_pkg::*;
(
  input  inst_t     instruction,
  output operands_t ops
);

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;

  assign opcode = instruction[OPCODE_MSB:OPCODE_LSB];
  assign rs     = instruction[RS_MSB:RS_LSB];
  assign rt     = instruction[RT_MSB:RT_LSB];
  assign rd     = instruction[RD_MSB:RD_LSB];

  always_comb begin
    ops          = '0;
    ops.src0     = rs;
    ops.src1     = rt;
    ops.dest     = rd;
    ops.pipe     = PIPE_ANY;
    ops.is_cmp   = (opcode inside {OP_CMP, OP_TEST, OP_CMPI, OP_TESTI});

    case (op_group_t'(opcode[5:4]))
      GRP_REG_ALU: begin
        if (opcode != OP_NOP) begin
          ops.use_mask = REG_MASK_RS0 | REG_MASK_RS1 | REG_MASK_RD;
        end
      end
      GRP_IMM_ALU: begin
        ops.dest     = rt;
        ops.use_mask = REG_MASK_RS0 | REG_MASK_RD;
      end
      GRP_MEMORY: begin
        ops.is_mem = 1'b1;
        ops.pipe   = PIPE_MEMORY;
        if (opcode == OP_LW) begin
          ops.dest     = rt;
          ops.use_mask = REG_MASK_RS0 | REG_MASK_RD;
        end else if (opcode == OP_SW) begin
          ops.use_mask = REG_MASK_RS0 | REG_MASK_RS1;
        end
      end
      default: begin
        // branches read no registers.
        ops.pipe      = PIPE_BRANCH;
        ops.is_branch = (opcode != OP_JMP);
      end
    endcase

    // compares feed the branch unit.
    if (ops.is_cmp) begin
      ops.pipe = PIPE_BRANCH;
    end
  end

endmodule

`default_nettype wire

//--- tb_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue
  import isa_pkg::*;
  import issue_pkg::*;
();

  logic        clk;
  logic        rst;
  logic        flush;
  logic        push0;
  logic        push1;
  iq_entry_t   push_data0;
  iq_entry_t   push_data1;
  logic        stall;
  issue_lane_t lane0;
  issue_lane_t lane1;

  integer   seed;
  int       cyc = 0;
  int       push_mark;
  int       k;
  inst_id_t next_id;

  // model window, position 0 oldest.
  iq_entry_t [IQ_DEPTH-1:0] m_win;
  iq_entry_t [IQ_DEPTH-1:0] n_win;
  int                       m_cnt;
  int                       n_cnt;
  int                       young;
  logic                     full;
  issue_lane_t              exp_l0;
  issue_lane_t              exp_l1;

  iq_entry_t e0;
  iq_entry_t e1;
  int        lane_a;
  int        lane_b;
  int        cyc_a;
  int        cyc_b;
  logic      stall_seen;

  issue_top UUT (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .push0      (push0),
    .push1      (push1),
    .push_data0 (push_data0),
    .push_data1 (push_data1),
    .stall      (stall),
    .lane0      (lane0),
    .lane1      (lane1)
  );

  always #2 clk = ~clk;

  // about 2000 cycles of tests, the rest is margin.
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc > 3000) begin
      $display("timeout: the run did not finish within 3000 cycles");
      $display("=== FAIL ===");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %0h expected %0h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic operands_t decode_inst(inst_t inst);
    operands_t o;
    opcode_t   op;
    o  = '0;
    op = inst[OPCODE_MSB:OPCODE_LSB];
    case (op[5:4])
      GRP_REG_ALU: begin
        if (op != OP_NOP) begin
          o.src0     = inst[RS_MSB:RS_LSB];
          o.src1     = inst[RT_MSB:RT_LSB];
          o.dest     = inst[RD_MSB:RD_LSB];
          o.use_mask = REG_MASK_RS0 | REG_MASK_RS1 | REG_MASK_RD;
        end
      end
      GRP_IMM_ALU: begin
        o.src0     = inst[RS_MSB:RS_LSB];
        o.dest     = inst[RT_MSB:RT_LSB];
        o.use_mask = REG_MASK_RS0 | REG_MASK_RD;
      end
      GRP_MEMORY: begin
        o.is_mem = 1'b1;
        o.pipe   = PIPE_MEMORY;
        o.src0   = inst[RS_MSB:RS_LSB];
        if (op == OP_LW) begin
          o.dest     = inst[RT_MSB:RT_LSB];
          o.use_mask = REG_MASK_RS0 | REG_MASK_RD;
        end else if (op == OP_SW) begin
          o.src1     = inst[RT_MSB:RT_LSB];
          o.use_mask = REG_MASK_RS0 | REG_MASK_RS1;
        end
      end
      default: begin
        o.pipe      = PIPE_BRANCH;
        o.is_branch = (op != OP_JMP);
      end
    endcase
    if (op == OP_CMP || op == OP_TEST || op == OP_CMPI || op == OP_TESTI) begin
      o.is_cmp = 1'b1;
      o.pipe   = PIPE_BRANCH; // compares go to the branch unit.
    end
    return o;
  endfunction

  // a reads a register that b writes.
  function automatic logic reads_from(operands_t a, operands_t b);
    logic hit;
    hit = (a.use_mask[0] && a.src0 == b.dest) || (a.use_mask[1] && a.src1 == b.dest);
    return b.use_mask[2] && hit;
  endfunction

  function automatic logic conflicts(operands_t yng, operands_t old, logic old_is_pick0);
    logic always_hit;
    logic waivable;
    always_hit = reads_from(yng, old) || (yng.is_mem && old.is_mem) ||
                 (yng.is_cmp && old.is_branch) || (yng.is_branch && old.is_cmp);
    waivable   = reads_from(old, yng) || old.is_branch ||
                 (yng.use_mask[2] && old.use_mask[2] && yng.dest == old.dest);
    return always_hit || (!old_is_pick0 && waivable);
  endfunction

  function automatic void ref_issue(input iq_entry_t [IQ_DEPTH-1:0] win, input int cnt,
                                    output issue_lane_t exp0, output issue_lane_t exp1,
                                    output int pick1);
    operands_t   first;
    operands_t   cand;
    issue_lane_t old_lane;
    issue_lane_t new_lane;
    logic        blocked;
    logic        swap;
    exp0  = '0;
    exp1  = '0;
    pick1 = -1;
    if (cnt > 0) begin
      first = decode_inst(win[0].instruction);
      for (int i = 1; i < cnt; i++) begin
        if (pick1 < 0) begin
          cand    = decode_inst(win[i].instruction);
          blocked = (first.pipe == PIPE_BRANCH && cand.pipe == PIPE_BRANCH) ||
                    (first.pipe == PIPE_MEMORY && cand.pipe == PIPE_MEMORY);
          for (int j = 0; j < i; j++) begin
            blocked = blocked | conflicts(cand, decode_inst(win[j].instruction), j == 0);
          end
          if (!blocked) begin
            pick1 = i;
          end
        end
      end
      old_lane = {1'b1, win[0]};
      new_lane = '0;
      swap     = (first.pipe == PIPE_MEMORY);
      if (pick1 > 0) begin
        new_lane = {1'b1, win[pick1]};
        cand     = decode_inst(win[pick1].instruction);
        swap     = swap || (cand.pipe == PIPE_BRANCH);
      end
      exp0 = swap ? new_lane : old_lane;
      exp1 = swap ? old_lane : new_lane;
    end
  endfunction

  // model step on the edge, compare once outputs settle.
  always @(posedge clk) begin
    if (rst || flush) begin
      exp_l0 = '0;
      exp_l1 = '0;
      m_cnt  = 0;
    end else begin
      ref_issue(m_win, m_cnt, exp_l0, exp_l1, young);
      full  = (m_cnt > IQ_DEPTH - 2);
      n_win = m_win;
      n_cnt = 0;
      for (int i = 1; i < m_cnt; i++) begin
        if (i != young) begin
          n_win[n_cnt] = m_win[i];
          n_cnt++;
        end
      end
      if (push0 && !full) begin
        n_win[n_cnt] = push_data0;
        n_cnt++;
      end
      if (push1 && !full) begin
        n_win[n_cnt] = push_data1;
        n_cnt++;
      end
      m_win = n_win;
      m_cnt = n_cnt;
    end
    #1;
    check_value("lane0.valid", lane0.valid, exp_l0.valid);
    check_value("lane1.valid", lane1.valid, exp_l1.valid);
    if (exp_l0.valid) check_value("lane0.entry", lane0.entry, exp_l0.entry);
    if (exp_l1.valid) check_value("lane1.entry", lane1.entry, exp_l1.entry);
    check_value("stall", stall, m_cnt > IQ_DEPTH - 2);
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic inst_t make_inst(opcode_t op, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic iq_entry_t make_entry(inst_t inst);
    iq_entry_t e;
    e.instruction = inst;
    e.pc          = 32'h1000 + {next_id, 2'b00};
    e.id          = next_id;
    next_id       = next_id + 1'b1;
    return e;
  endfunction

  function automatic reg_idx_t small_reg();
    return reg_idx_t'(1 + $unsigned($random(seed)) % 3); // few names, many hazards.
  endfunction

  task automatic rand_entry(output iq_entry_t e);
    opcode_t op;
    int      sel;
    sel = $unsigned($random(seed)) % 12;
    case (sel)
      0:       op = OP_NOP;
      1:       op = {GRP_REG_ALU, 4'd1};
      2:       op = OP_CMP;
      3:       op = OP_TEST;
      4:       op = {GRP_IMM_ALU, 4'd1};
      5:       op = OP_CMPI;
      6:       op = OP_TESTI;
      7:       op = OP_LW;
      8:       op = OP_SW;
      9:       op = {GRP_MEMORY, 4'd2};
      10:      op = OP_JMP;
      default: op = {GRP_BRANCH, 4'd1};
    endcase
    e    = make_entry(make_inst(op, small_reg(), small_reg(), small_reg()));
    e.pc = $random(seed);
  endtask

  // one cycle of pushes, cleared again on the next falling edge.
  task automatic push_pair(input logic p0, input iq_entry_t d0,
                           input logic p1, input iq_entry_t d1);
    @(negedge clk);
    push_mark  = cyc;
    push0      = p0;
    push1      = p1;
    push_data0 = d0;
    push_data1 = d1;
    @(negedge clk);
    push0 = 1'b0;
    push1 = 1'b0;
  endtask

  task automatic find_lane(input inst_id_t id, output int lane, output int when);
    lane = -1;
    while (lane < 0) begin
      if (lane0.valid && lane0.entry.id == id) begin
        lane = 0;
      end else if (lane1.valid && lane1.entry.id == id) begin
        lane = 1;
      end else begin
        @(posedge clk);
        #1;
      end
    end
    when = cyc;
  endtask

  task automatic wait_empty();
    while (m_cnt != 0) @(negedge clk);
    @(negedge clk);
  endtask

  initial begin
    seed       = 32'hb68b_e24c;
    clk        = 1'b0;
    rst        = 1'b1;
    flush      = 1'b0;
    push0      = 1'b0;
    push1      = 1'b0;
    push_data0 = '0;
    push_data1 = '0;
    next_id    = '0;
    m_win      = '0;
    m_cnt      = 0;
    stall_seen = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // single alu, then single load.
    e0 = make_entry(make_inst({GRP_REG_ALU, 4'd1}, 5'd1, 5'd2, 5'd3));
    push_pair(1'b1, e0, 1'b0, e0);
    find_lane(e0.id, lane_a, cyc_a);
    check_value("alu lane", lane_a, 0);
    check_value("push to issue edges", cyc_a - push_mark, 2);
    e0 = make_entry(make_inst(OP_LW, 5'd1, 5'd2, 5'd0));
    push_pair(1'b1, e0, 1'b0, e0);
    find_lane(e0.id, lane_a, cyc_a);
    check_value("load lane", lane_a, 1);

    // independent pair, then dependent pair.
    e0 = make_entry(make_inst({GRP_REG_ALU, 4'd1}, 5'd1, 5'd2, 5'd3));
    e1 = make_entry(make_inst({GRP_REG_ALU, 4'd1}, 5'd4, 5'd5, 5'd6));
    push_pair(1'b1, e0, 1'b1, e1);
    find_lane(e0.id, lane_a, cyc_a);
    find_lane(e1.id, lane_b, cyc_b);
    check_value("older alu lane", lane_a, 0);
    check_value("younger alu lane", lane_b, 1);
    check_value("alu pair issue gap", cyc_b - cyc_a, 0);
    e0 = make_entry(make_inst({GRP_REG_ALU, 4'd1}, 5'd1, 5'd2, 5'd3));
    e1 = make_entry(make_inst({GRP_REG_ALU, 4'd1}, 5'd3, 5'd4, 5'd5));
    push_pair(1'b1, e0, 1'b1, e1);
    find_lane(e0.id, lane_a, cyc_a);
    find_lane(e1.id, lane_b, cyc_b);
    check_value("dependent pair issue gap", cyc_b - cyc_a, 1);

    // memory pairs split, memory plus branch together.
    e0 = make_entry(make_inst(OP_LW, 5'd1, 5'd2, 5'd0));
    e1 = make_entry(make_inst(OP_LW, 5'd3, 5'd4, 5'd0));
    push_pair(1'b1, e0, 1'b1, e1);
    find_lane(e0.id, lane_a, cyc_a);
    find_lane(e1.id, lane_b, cyc_b);
    check_value("memory pair together", cyc_a == cyc_b, 0);
    e0 = make_entry(make_inst(OP_SW, 5'd1, 5'd2, 5'd0));
    e1 = make_entry(make_inst({GRP_BRANCH, 4'd1}, 5'd0, 5'd0, 5'd0));
    push_pair(1'b1, e0, 1'b1, e1);
    find_lane(e0.id, lane_a, cyc_a);
    find_lane(e1.id, lane_b, cyc_b);
    check_value("store lane", lane_a, 1);
    check_value("branch lane", lane_b, 0);
    check_value("store branch issue gap", cyc_b - cyc_a, 0);
    wait_empty();

    // loads only leave one per cycle, so the window fills.
    for (k = 0; k < 12; k++) begin
      @(negedge clk);
      stall_seen = stall_seen | stall;
      push0      = 1'b1;
      push1      = 1'b1;
      push_data0 = make_entry(make_inst(OP_LW, 5'd1, 5'd2, 5'd0));
      push_data1 = make_entry(make_inst(OP_LW, 5'd3, 5'd4, 5'd0));
    end
    @(negedge clk);
    push0 = 1'b0;
    push1 = 1'b0;
    check_value("stall seen", stall_seen, 1);
    wait_empty();

    // flush mid stream.
    for (k = 0; k < 3; k++) begin
      @(negedge clk);
      push0      = 1'b1;
      push1      = 1'b1;
      push_data0 = make_entry(make_inst(OP_LW, 5'd1, 5'd2, 5'd0));
      push_data1 = make_entry(make_inst(OP_LW, 5'd3, 5'd4, 5'd0));
    end
    @(negedge clk);
    flush      = 1'b1;
    push_data0 = make_entry(make_inst({GRP_REG_ALU, 4'd1}, 5'd1, 5'd2, 5'd3));
    @(negedge clk);
    flush = 1'b0;
    push0 = 1'b0;
    push1 = 1'b0;
    check_value("lane0.valid after flush", lane0.valid, 0);
    check_value("lane1.valid after flush", lane1.valid, 0);
    repeat (4) @(negedge clk);

    // random stream, source honors stall.
    for (k = 0; k < 1800; k++) begin
      @(negedge clk);
      rand_entry(e0);
      rand_entry(e1);
      push0      = !stall && ($random(seed) & 1);
      push1      = !stall && ($random(seed) & 1);
      push_data0 = e0;
      push_data1 = e1;
    end
    @(negedge clk);
    push0 = 1'b0;
    push1 = 1'b0;
    wait_empty();
    repeat (2) @(negedge clk);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
isa_pkg.sv
issue_pkg.sv
reg_decode.sv
issue_window.sv
issue_select.sv
issue_route.sv
issue_top.sv
tb_issue.sv
